// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // datapath and address width
    localparam int XLEN = 32;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // sequential fetch step
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // size code driven on inst_sram_size for a word read
    localparam logic [1:0] INST_SIZE_WORD = 2'd2;

    // deepest stack of cancelled responses still due from memory
    localparam int MAX_STALE = 3;
    localparam int STALE_W = $clog2(MAX_STALE + 1);

    // source of a pending redirect
    // a lower nonzero code has higher priority
    typedef enum logic [1:0] {
        REDIR_NONE   = 2'd0,
        REDIR_ERTN   = 2'd1,
        REDIR_EXC    = 2'd2,
        REDIR_BRANCH = 2'd3
    } redirect_kind_e;

endpackage

// ==== fetch/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       resetn,
    output logic                       inst_sram_req,
    output logic [1:0]                 inst_sram_size,
    output logic [fetch_pkg::XLEN-1:0] inst_sram_addr,
    input  logic                       inst_sram_addr_ok,
    input  logic [fetch_pkg::XLEN-1:0] inst_sram_rdata,
    input  logic                       data_keep,
    input  logic                       redir_valid,
    input  logic [fetch_pkg::XLEN-1:0] redir_pc,
    input  logic                       br_stall,
    input  logic                       if_flush,
    input  logic                       id_allowin,
    output logic                       addr_accepted,
    output logic                       redirect_cancel,
    output logic                       in_flight,
    output logic                       if_to_id_valid,
    output logic [fetch_pkg::XLEN-1:0] if_to_id_pc,
    output logic [fetch_pkg::XLEN-1:0] if_to_id_inst,
    output logic                       if_to_id_adef
);

    logic                       fetch_en;
    logic                       stage_valid;
    logic [fetch_pkg::XLEN-1:0] stage_pc;
    logic                       resp_pending;
    logic                       buf_valid;
    logic [fetch_pkg::XLEN-1:0] buf_inst;
    logic                       kill;
    logic                       ready_go;
    logic                       handoff;
    logic                       allowin;

    // current entry is on a dead path
    assign kill     = redir_valid || if_flush;
    assign ready_go = data_keep || buf_valid;

    assign if_to_id_valid = stage_valid && ready_go && !kill;
    assign handoff        = if_to_id_valid && id_allowin;
    assign allowin        = !stage_valid || handoff || kill;

    assign inst_sram_req   = fetch_en && allowin && !br_stall;
    assign inst_sram_size  = fetch_pkg::INST_SIZE_WORD;
    assign inst_sram_addr  = redir_valid ? redir_pc : stage_pc + fetch_pkg::PC_STEP;
    assign addr_accepted   = inst_sram_req && inst_sram_addr_ok;

    assign in_flight       = resp_pending;
    // killed while its word is still out in memory
    assign redirect_cancel = kill && resp_pending && !data_keep;

    assign if_to_id_pc   = stage_pc;
    assign if_to_id_inst = buf_valid ? buf_inst : inst_sram_rdata;
    assign if_to_id_adef = |stage_pc[1:0];

    // first request goes out one cycle after reset is released
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (allowin) begin
            stage_valid <= addr_accepted;
        end
    end

    // one before RESET_PC so the first sequential address is RESET_PC
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_pc <= fetch_pkg::RESET_PC - fetch_pkg::PC_STEP;
        end else if (addr_accepted) begin
            stage_pc <= inst_sram_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            resp_pending <= 1'b0;
        end else if (addr_accepted) begin
            resp_pending <= 1'b1;
        end else if (data_keep || kill) begin
            resp_pending <= 1'b0;
        end
    end

    // park the word while decode is busy
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (handoff || kill) begin
            buf_valid <= 1'b0;
        end else if (data_keep) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_keep) begin
            buf_inst <= inst_sram_rdata;
        end
    end

    // stalled output keeps its pc and word into the next cycle
    stable_under_stall: assert property (@(posedge clk) disable iff (!resetn)
        (if_to_id_valid && !id_allowin) |=>
            ($stable(if_to_id_pc) && $stable(if_to_id_inst)));

endmodule

// ==== fetch/redirect_hold.sv ====
`timescale 1ns/1ps

module redirect_hold (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       br_taken,
    input  logic [fetch_pkg::XLEN-1:0] br_target,
    input  logic                       exc_valid,
    input  logic [fetch_pkg::XLEN-1:0] exc_entry,
    input  logic                       ertn_valid,
    input  logic [fetch_pkg::XLEN-1:0] ertn_target,
    input  logic                       addr_accepted,
    output logic                       redir_valid,
    output logic [fetch_pkg::XLEN-1:0] redir_pc
);

    fetch_pkg::redirect_kind_e  live_kind;
    logic [fetch_pkg::XLEN-1:0] live_pc;
    fetch_pkg::redirect_kind_e  held_kind;
    logic [fetch_pkg::XLEN-1:0] held_pc;
    logic                       use_live;

    // pick the strongest pulse of this cycle
    always_comb begin
        if (ertn_valid) begin
            live_kind = fetch_pkg::REDIR_ERTN;
            live_pc   = ertn_target;
        end else if (exc_valid) begin
            live_kind = fetch_pkg::REDIR_EXC;
            live_pc   = exc_entry;
        end else if (br_taken) begin
            live_kind = fetch_pkg::REDIR_BRANCH;
            live_pc   = br_target;
        end else begin
            live_kind = fetch_pkg::REDIR_NONE;
            live_pc   = br_target;
        end
    end

    // same kind as held loses, held one came first
    assign use_live = (live_kind != fetch_pkg::REDIR_NONE) &&
                      ((held_kind == fetch_pkg::REDIR_NONE) || (live_kind < held_kind));

    assign redir_valid = use_live || (held_kind != fetch_pkg::REDIR_NONE);
    assign redir_pc    = use_live ? live_pc : held_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held_kind <= fetch_pkg::REDIR_NONE;
        end else if (addr_accepted) begin
            held_kind <= fetch_pkg::REDIR_NONE;
        end else if (use_live) begin
            held_kind <= live_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (use_live && !addr_accepted) begin
            held_pc <= live_pc;
        end
    end

    // a stored target survives until the port takes it
    held_until_accept: assert property (@(posedge clk) disable iff (!resetn)
        (redir_valid && !addr_accepted) |=> (held_kind != fetch_pkg::REDIR_NONE));

endmodule

// ==== fetch/response_filter.sv ====
`timescale 1ns/1ps

module response_filter (
    input  logic clk,
    input  logic resetn,
    input  logic redirect_cancel,
    input  logic inst_sram_data_ok,
    input  logic in_flight,
    output logic data_keep
);

    logic [fetch_pkg::STALE_W-1:0] stale_cnt;
    logic                          stale_inc;
    logic                          stale_dec;

    // one more response on its way that nobody wants
    assign stale_inc = redirect_cancel && in_flight && (stale_cnt < fetch_pkg::MAX_STALE);

    // a returning word pays off one stale slot first
    assign stale_dec = inst_sram_data_ok && (stale_cnt != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stale_cnt <= '0;
        end else if (stale_inc && !stale_dec) begin
            stale_cnt <= stale_cnt + 1'b1;
        end else if (stale_dec && !stale_inc) begin
            stale_cnt <= stale_cnt - 1'b1;
        end
    end

    assign data_keep = inst_sram_data_ok && (stale_cnt == '0);

    // fetch never cancels more requests than the counter can track
    no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        (redirect_cancel && in_flight) |-> (stale_cnt < fetch_pkg::MAX_STALE));

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                       clk,
    input  logic                       resetn,
    output logic                       inst_sram_req,
    output logic [1:0]                 inst_sram_size,
    output logic [fetch_pkg::XLEN-1:0] inst_sram_addr,
    input  logic                       inst_sram_addr_ok,
    input  logic                       inst_sram_data_ok,
    input  logic [fetch_pkg::XLEN-1:0] inst_sram_rdata,
    input  logic                       br_taken,
    input  logic [fetch_pkg::XLEN-1:0] br_target,
    input  logic                       exc_valid,
    input  logic [fetch_pkg::XLEN-1:0] exc_entry,
    input  logic                       ertn_valid,
    input  logic [fetch_pkg::XLEN-1:0] ertn_target,
    input  logic                       br_stall,
    input  logic                       if_flush,
    input  logic                       id_allowin,
    output logic                       if_to_id_valid,
    output logic [fetch_pkg::XLEN-1:0] if_to_id_pc,
    output logic [fetch_pkg::XLEN-1:0] if_to_id_inst,
    output logic                       if_to_id_adef
);

    logic                       addr_accepted;
    logic                       redir_valid;
    logic [fetch_pkg::XLEN-1:0] redir_pc;
    logic                       redirect_cancel;
    logic                       in_flight;
    logic                       data_keep;

    redirect_hold i_redirect_hold (
        .clk           (clk),
        .resetn        (resetn),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .exc_valid     (exc_valid),
        .exc_entry     (exc_entry),
        .ertn_valid    (ertn_valid),
        .ertn_target   (ertn_target),
        .addr_accepted (addr_accepted),
        .redir_valid   (redir_valid),
        .redir_pc      (redir_pc)
    );

    response_filter i_response_filter (
        .clk               (clk),
        .resetn            (resetn),
        .redirect_cancel   (redirect_cancel),
        .inst_sram_data_ok (inst_sram_data_ok),
        .in_flight         (in_flight),
        .data_keep         (data_keep)
    );

    fetch_stage i_fetch_stage (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_size    (inst_sram_size),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_keep         (data_keep),
        .redir_valid       (redir_valid),
        .redir_pc          (redir_pc),
        .br_stall          (br_stall),
        .if_flush          (if_flush),
        .id_allowin        (id_allowin),
        .addr_accepted     (addr_accepted),
        .redirect_cancel   (redirect_cancel),
        .in_flight         (in_flight),
        .if_to_id_valid    (if_to_id_valid),
        .if_to_id_pc       (if_to_id_pc),
        .if_to_id_inst     (if_to_id_inst),
        .if_to_id_adef     (if_to_id_adef)
    );

endmodule

// ==== src.f ====
common/fetch_pkg.sv
fetch/redirect_hold.sv
fetch/response_filter.sv
fetch/fetch_stage.sv
logic/fetch_top.sv
tb/inst_sram_model.sv
tb/tb_fetch_top.sv

// ==== tb/inst_sram_model.sv ====
`timescale 1ns/1ps

module inst_sram_model (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       slow,
    input  logic                       block,
    input  logic                       req,
    input  logic [fetch_pkg::XLEN-1:0] addr,
    output logic                       addr_ok,
    output logic                       data_ok,
    output logic [fetch_pkg::XLEN-1:0] rdata
);

    localparam logic [fetch_pkg::XLEN-1:0] DATA_KEY = 32'h5a5a_0000;

    logic [31:0]                lfsr;
    logic                       slow_r;
    logic                       block_r;
    int                         cyc;
    int                         next_lat;
    logic [fetch_pkg::XLEN-1:0] addr_q[$];
    int                         due_q[$];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    initial begin
        lfsr     = 32'h215f_b2a4;
        slow_r   = 1'b0;
        block_r  = 1'b0;
        cyc      = 0;
        next_lat = 1;
        addr_ok  = 1'b0;
        data_ok  = 1'b0;
        rdata    = '0;
    end

    // accept and retire on the rising edge
    always @(posedge clk) begin
        slow_r  = slow;
        block_r = block;
        if (!resetn) begin
            addr_q.delete();
            due_q.delete();
            cyc = 0;
        end else begin
            cyc = cyc + 1;
            if (data_ok) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (req && addr_ok) begin
                addr_q.push_back(addr);
                due_q.push_back(cyc + next_lat);
            end
        end
    end

    // responses in request order, one per cycle
    always @(negedge clk) begin
        int bits;
        draw_bits(2, bits);
        addr_ok = !block_r && (bits != 0);
        draw_bits(2, bits);
        next_lat = (slow_r ? 6 : 1) + bits;
        data_ok  = (due_q.size() != 0) && (cyc >= due_q[0]);
        rdata    = data_ok ? (addr_q[0] ^ DATA_KEY) : '0;
    end

endmodule

// ==== tb/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;

    localparam logic [fetch_pkg::XLEN-1:0] DATA_KEY = 32'h5a5a_0000;
    localparam int TIMEOUT = 300;

    logic                       clk = 1'b0;
    logic                       resetn;
    logic                       inst_sram_req;
    logic [1:0]                 inst_sram_size;
    logic [fetch_pkg::XLEN-1:0] inst_sram_addr;
    logic                       inst_sram_addr_ok;
    logic                       inst_sram_data_ok;
    logic [fetch_pkg::XLEN-1:0] inst_sram_rdata;
    logic                       br_taken;
    logic [fetch_pkg::XLEN-1:0] br_target;
    logic                       exc_valid;
    logic [fetch_pkg::XLEN-1:0] exc_entry;
    logic                       ertn_valid;
    logic [fetch_pkg::XLEN-1:0] ertn_target;
    logic                       br_stall;
    logic                       if_flush;
    logic                       id_allowin;
    logic                       if_to_id_valid;
    logic [fetch_pkg::XLEN-1:0] if_to_id_pc;
    logic [fetch_pkg::XLEN-1:0] if_to_id_inst;
    logic                       if_to_id_adef;
    logic                       slow;
    logic                       block;

    logic [31:0]                lfsr;
    int                         checks;
    int                         errors;
    logic [fetch_pkg::XLEN-1:0] dlv_pc[$];
    logic [fetch_pkg::XLEN-1:0] dlv_inst[$];
    logic                       dlv_adef[$];

    fetch_top i_fetch_top (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_size    (inst_sram_size),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .exc_valid         (exc_valid),
        .exc_entry         (exc_entry),
        .ertn_valid        (ertn_valid),
        .ertn_target       (ertn_target),
        .br_stall          (br_stall),
        .if_flush          (if_flush),
        .id_allowin        (id_allowin),
        .if_to_id_valid    (if_to_id_valid),
        .if_to_id_pc       (if_to_id_pc),
        .if_to_id_inst     (if_to_id_inst),
        .if_to_id_adef     (if_to_id_adef)
    );

    inst_sram_model i_mem (
        .clk     (clk),
        .resetn  (resetn),
        .slow    (slow),
        .block   (block),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // decode back-pressure, one random bit per cycle
    always @(negedge clk) begin
        lfsr       = lfsr_next(lfsr);
        id_allowin = lfsr[0];
    end

    // every handoff to decode
    always @(posedge clk) begin
        if (resetn && if_to_id_valid && id_allowin) begin
            dlv_pc.push_back(if_to_id_pc);
            dlv_inst.push_back(if_to_id_inst);
            dlv_adef.push_back(if_to_id_adef);
        end
    end

    // every address the port takes is a word read
    always @(posedge clk) begin
        if (resetn && inst_sram_req && inst_sram_addr_ok) begin
            check_size("inst_port", fetch_pkg::INST_SIZE_WORD, inst_sram_size);
        end
    end

    task automatic check_pc(input string name, input logic [fetch_pkg::XLEN-1:0] exp,
                            input logic [fetch_pkg::XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s pc expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input logic [fetch_pkg::XLEN-1:0] exp,
                              input logic [fetch_pkg::XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s inst expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s flag expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s size expected %h actual %h", name, exp, act);
        end
    endtask

    // n handoffs from index first, sequential from start_pc
    task automatic check_stream(input string name, input int first,
                                input logic [fetch_pkg::XLEN-1:0] start_pc, input int n);
        logic [fetch_pkg::XLEN-1:0] pc;
        for (int i = 0; i < n; i++) begin
            pc = start_pc + 4 * i;
            check_pc(name, pc, dlv_pc[first + i]);
            check_inst(name, pc ^ DATA_KEY, dlv_inst[first + i]);
            check_flag(name, |pc[1:0], dlv_adef[first + i]);
        end
    endtask

    task automatic wait_deliveries(input int n, output bit ok);
        int i;
        i = 0;
        while (dlv_pc.size() < n && i < TIMEOUT) begin
            @(negedge clk);
            i++;
        end
        ok = (dlv_pc.size() >= n);
        if (!ok) begin
            errors++;
            $display("timeout: only %0d of %0d instructions reached decode", dlv_pc.size(), n);
        end
    endtask

    task automatic wait_accept(output bit ok);
        int i;
        i = 0;
        ok = 0;
        while (!ok && i < TIMEOUT) begin
            @(posedge clk);
            ok = inst_sram_req && inst_sram_addr_ok;
            i++;
        end
        if (!ok) begin
            errors++;
            $display("timeout: the instruction port accepted no address");
        end
    endtask

    task automatic redirect_branch(input logic [fetch_pkg::XLEN-1:0] target, output int mark);
        @(negedge clk);
        mark      = dlv_pc.size();
        br_taken  = 1'b1;
        br_target = target;
        @(negedge clk);
        br_taken = 1'b0;
    endtask

    task automatic test_sequential();
        bit ok;
        wait_deliveries(12, ok);
        if (!ok) return;
        check_stream("test_sequential", 0, fetch_pkg::RESET_PC, 12);
    endtask

    task automatic test_branch();
        int mark;
        bit ok;
        redirect_branch(32'h1c00_0400, mark);
        wait_deliveries(mark + 6, ok);
        if (!ok) return;
        check_stream("test_branch", mark, 32'h1c00_0400, 6);
    endtask

    task automatic test_cancel();
        int mark1;
        int mark2;
        bit ok;
        @(negedge clk);
        slow = 1'b1;
        wait_accept(ok);
        if (!ok) return;
        redirect_branch(32'h1c00_0800, mark1);
        wait_accept(ok);
        if (!ok) return;
        // second cancel while the first target is still out
        redirect_branch(32'h1c00_0900, mark2);
        wait_deliveries(mark2 + 4, ok);
        if (!ok) return;
        check_stream("test_cancel", mark1, 32'h1c00_0800, mark2 - mark1);
        check_stream("test_cancel", mark2, 32'h1c00_0900, 4);
        @(negedge clk);
        slow = 1'b0;
    endtask

    task automatic test_priority();
        int mark;
        bit ok;
        @(negedge clk);
        mark        = dlv_pc.size();
        ertn_valid  = 1'b1;
        ertn_target = 32'h1c00_2000;
        exc_valid   = 1'b1;
        exc_entry   = 32'h1c00_3000;
        @(negedge clk);
        ertn_valid = 1'b0;
        exc_valid  = 1'b0;
        wait_deliveries(mark + 3, ok);
        if (!ok) return;
        check_stream("test_priority", mark, 32'h1c00_2000, 3);
        // hold a branch with addr_ok low, then an exception overrides it
        @(negedge clk);
        block = 1'b1;
        @(negedge clk);
        mark      = dlv_pc.size();
        br_taken  = 1'b1;
        br_target = 32'h1c00_5000;
        @(negedge clk);
        br_taken  = 1'b0;
        exc_valid = 1'b1;
        exc_entry = 32'h1c00_6000;
        @(negedge clk);
        exc_valid = 1'b0;
        block     = 1'b0;
        wait_deliveries(mark + 3, ok);
        if (!ok) return;
        check_stream("test_priority", mark, 32'h1c00_6000, 3);
    endtask

    task automatic test_adef_stall();
        int mark;
        bit ok;
        redirect_branch(32'h1c00_4002, mark);
        wait_deliveries(mark + 3, ok);
        if (!ok) return;
        @(negedge clk);
        br_stall = 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_flag("test_adef_stall", 1'b0, inst_sram_req);
        end
        @(negedge clk);
        br_stall = 1'b0;
        wait_deliveries(mark + 6, ok);
        if (!ok) return;
        check_stream("test_adef_stall", mark, 32'h1c00_4002, 6);
    endtask

    task automatic test_flush();
        int mark;
        bit ok;
        @(negedge clk);
        if_flush = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_flag("test_flush", 1'b0, if_to_id_valid);
        end
        @(negedge clk);
        if_flush = 1'b0;
        // fetch resumes on its own first, then takes a known target
        wait_deliveries(dlv_pc.size() + 1, ok);
        if (!ok) return;
        redirect_branch(32'h1c00_7000, mark);
        wait_deliveries(mark + 3, ok);
        if (!ok) return;
        check_stream("test_flush", mark, 32'h1c00_7000, 3);
    endtask

    initial begin
        resetn      = 1'b0;
        br_taken    = 1'b0;
        br_target   = '0;
        exc_valid   = 1'b0;
        exc_entry   = '0;
        ertn_valid  = 1'b0;
        ertn_target = '0;
        br_stall    = 1'b0;
        if_flush    = 1'b0;
        id_allowin  = 1'b1;
        slow        = 1'b0;
        block       = 1'b0;
        lfsr        = 32'h215f_b2a4;
        checks      = 0;
        errors      = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        test_sequential();
        test_branch();
        test_cancel();
        test_priority();
        test_adef_stall();
        test_flush();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
